// File: common/etx_pkg.sv
/*
 shared constants and types for the link transmit path
 register index is taken from address bits [rfaw+1:2], word accesses only
 packet layout is fixed at 104 bits, msb first on the pins
*/
package etx_pkg;

   // #################### bus
   localparam int addr_width  = 20;  // mi address width
   localparam int data_width  = 32;  // mi data width
   localparam int rfaw        = 4;   // register index width
   localparam int group_width = 4;   // top address bits vs GROUP

   // register indices
   localparam logic [rfaw-1:0] reg_cfg     = 4'd0;
   localparam logic [rfaw-1:0] reg_status  = 4'd1;
   localparam logic [rfaw-1:0] reg_gpio    = 4'd2;
   localparam logic [rfaw-1:0] reg_test    = 4'd3;
   localparam logic [rfaw-1:0] reg_dstaddr = 4'd4;
   localparam logic [rfaw-1:0] reg_data    = 4'd5;
   localparam logic [rfaw-1:0] reg_srcaddr = 4'd6;

   // #################### register fields
   localparam int cfg_width        = 11;
   localparam int cfg_tx_enable    = 0;
   localparam int cfg_mmu_enable   = 1;   // stored only
   localparam int cfg_remap_lsb    = 2;   // 2 bits, active when 1
   localparam int cfg_ctrlmode_lsb = 4;   // 4 bits
   localparam int cfg_ctrlmode_bp  = 8;
   localparam int cfg_pin_mode_lsb = 9;   // 2 bits
   localparam int gpio_width       = 9;   // 8 data pins + frame
   localparam int test_width       = 9;
   localparam int test_loop        = 8;   // continuous test packets
   localparam int status_width     = 16;
   localparam int fcnt_width       = 13;

   // pin modes, code 3 behaves as normal
   localparam logic [1:0] pin_mode_normal  = 2'd0;
   localparam logic [1:0] pin_mode_gpio    = 2'd1;
   localparam logic [1:0] pin_mode_pattern = 2'd2;

   // #################### packet
   localparam int pkt_width = 104;
   localparam int pkt_bytes = pkt_width / 8;   // 13 bytes per frame

   typedef struct packed {
      logic [31:0] srcaddr;
      logic [31:0] data;
      logic [31:0] dstaddr;
      logic        write;
      logic [1:0]  datamode;
      logic [3:0]  ctrlmode;
      logic        spare;
   } etx_packet_t;

   typedef struct packed {
      logic [fcnt_width-1:0] frame_count;   // frames sent, wraps
      logic                  test_dropped;  // pulse
      logic                  wait_seen;     // pulse
      logic                  spare;
   } etx_debug_t;

endpackage

// File: common/mi_if.sv
/*
 simple memory interface, single 32 bit word per access
 read data is registered in the slave, valid one cycle after en
*/
`timescale 1ns/100ps

interface mi_if;

   logic                           en;    // access strobe
   logic                           we;    // 1 write, 0 read
   logic [etx_pkg::addr_width-1:0] addr;  // byte address
   logic [etx_pkg::data_width-1:0] din;   // write data
   logic [etx_pkg::data_width-1:0] dout;  // read data, held until next read

   modport master
   (
      output en, we, addr, din,
      input  dout
   );

   modport slave
   (
      input  en, we, addr, din,
      output dout
   );

endinterface

// File: ecfg/ecfg_tx.sv
/*
 transmit config and status registers on the mi bus
 accesses outside GROUP are ignored, read data then stays as it was
 unlisted indices read zero, mmu enable is stored but drives nothing
*/
`timescale 1ns/100ps

module ecfg_tx
#(
   parameter logic [etx_pkg::group_width-1:0] GROUP = '0
)
(
   input  logic                               sys_clk,
   input  logic                               reset,
   mi_if.slave                                mi,
   input  etx_pkg::etx_debug_t                tx_debug,
   output logic                               tx_enable,
   output logic                               remap_enable,
   output logic                               ctrlmode_bp,
   output logic [3:0]                         ctrlmode,
   output logic [1:0]                         pin_mode,
   output logic [etx_pkg::gpio_width-1:0]     gpio_data,
   output logic                               test_access,
   output etx_pkg::etx_packet_t               test_packet
);

   logic [etx_pkg::group_width-1:0]  group_sel;
   logic [etx_pkg::rfaw-1:0]         reg_idx;
   logic                             cfg_hit;
   logic                             reg_wr;
   logic                             reg_rd;
   logic [etx_pkg::cfg_width-1:0]    cfg_reg;
   logic [etx_pkg::gpio_width-1:0]   gpio_reg;
   logic [etx_pkg::test_width-1:0]   test_reg;
   logic [31:0]                      dstaddr_reg;
   logic [31:0]                      data_reg;
   logic [31:0]                      srcaddr_reg;
   logic [etx_pkg::status_width-1:0] status_reg;
   logic [etx_pkg::data_width-1:0]   rd_mux;

   // #################### decode
   assign group_sel = mi.addr[etx_pkg::addr_width-1 -: etx_pkg::group_width];
   assign reg_idx   = mi.addr[etx_pkg::rfaw+1:2];   // word index
   assign cfg_hit   = group_sel == GROUP;
   assign reg_wr    = mi.en & mi.we & cfg_hit;
   assign reg_rd    = mi.en & ~mi.we & cfg_hit;

   // #################### writable registers
   always_ff @(posedge sys_clk or posedge reset)
   begin
      if (reset)
      begin
         cfg_reg     <= '0;
         gpio_reg    <= '0;
         test_reg    <= '0;
         dstaddr_reg <= '0;
         data_reg    <= '0;
         srcaddr_reg <= '0;
      end
      else if (reg_wr)
      begin
         case (reg_idx)
            etx_pkg::reg_cfg:     cfg_reg     <= mi.din[etx_pkg::cfg_width-1:0];
            etx_pkg::reg_gpio:    gpio_reg    <= mi.din[etx_pkg::gpio_width-1:0];
            etx_pkg::reg_test:    test_reg    <= mi.din[etx_pkg::test_width-1:0];
            etx_pkg::reg_dstaddr: dstaddr_reg <= mi.din;
            etx_pkg::reg_data:    data_reg    <= mi.din;
            etx_pkg::reg_srcaddr: srcaddr_reg <= mi.din;
            default:              ;   // status handled below, rest read-only zero
         endcase
      end
   end

   // config fields out to the datapath
   assign tx_enable    = cfg_reg[etx_pkg::cfg_tx_enable];
   assign remap_enable = cfg_reg[etx_pkg::cfg_remap_lsb +: 2] == 2'b01;
   assign ctrlmode     = cfg_reg[etx_pkg::cfg_ctrlmode_lsb +: 4];
   assign ctrlmode_bp  = cfg_reg[etx_pkg::cfg_ctrlmode_bp];
   assign pin_mode     = cfg_reg[etx_pkg::cfg_pin_mode_lsb +: 2];
   assign gpio_data    = gpio_reg;   // straight to the pins in gpio mode

   // #################### status
   // low bits collect debug pulses, upper bits follow the frame counter
   always_ff @(posedge sys_clk or posedge reset)
   begin
      if (reset)
         status_reg <= '0;
      else if (reg_wr && reg_idx == etx_pkg::reg_status)
         status_reg <= mi.din[etx_pkg::status_width-1:0];   // sw clears sticky bits
      else
      begin
         status_reg[2:0] <= status_reg[2:0] |
                            {tx_debug.test_dropped, tx_debug.wait_seen, tx_debug.spare};
         status_reg[etx_pkg::status_width-1:3] <= tx_debug.frame_count;
      end
   end

   // #################### test packet
   // ctrl byte taken as is from test[7:0]
   assign test_packet = {srcaddr_reg, data_reg, dstaddr_reg, test_reg[7:0]};

   always_ff @(posedge sys_clk or posedge reset)
   begin
      if (reset)
         test_access <= 1'b0;
      else
         test_access <= (reg_wr && reg_idx == etx_pkg::reg_test && mi.din[0]) ||
                        test_reg[etx_pkg::test_loop];   // one pulse or loop level
   end

   // #################### readback
   always_comb
   begin
      rd_mux = '0;
      case (reg_idx)
         etx_pkg::reg_cfg:     rd_mux[etx_pkg::cfg_width-1:0]    = cfg_reg;
         etx_pkg::reg_status:  rd_mux[etx_pkg::status_width-1:0] = status_reg;
         etx_pkg::reg_gpio:    rd_mux[etx_pkg::gpio_width-1:0]   = gpio_reg;
         etx_pkg::reg_test:    rd_mux[etx_pkg::test_width-1:0]   = test_reg;
         etx_pkg::reg_dstaddr: rd_mux = dstaddr_reg;
         etx_pkg::reg_data:    rd_mux = data_reg;
         etx_pkg::reg_srcaddr: rd_mux = srcaddr_reg;
         default:              rd_mux = '0;
      endcase
   end

   always_ff @(posedge sys_clk)
   begin
      if (reg_rd)
         mi.dout <= rd_mux;   // one cycle read latency
   end

endmodule

// File: etx/etx_packet_sel.sv
/*
 one-entry packet holding register, test request beats normal packets
 a test request that finds the entry full is dropped and flagged
 ctrlmode override and dstaddr remap are applied on capture
*/
`timescale 1ns/100ps

module etx_packet_sel
#(
   parameter logic [11:0] CHIP_ID = 12'h808
)
(
   input  logic                  sys_clk,
   input  logic                  reset,
   input  logic                  tx_access,
   input  etx_pkg::etx_packet_t  tx_packet,
   output logic                  tx_ready,
   input  logic                  test_access,
   input  etx_pkg::etx_packet_t  test_packet,
   input  logic                  tx_enable,
   input  logic                  remap_enable,
   input  logic                  ctrlmode_bp,
   input  logic [3:0]            ctrlmode,
   output logic                  sel_valid,
   output etx_pkg::etx_packet_t  sel_packet,
   input  logic                  sel_ready,
   output logic                  test_drop
);

   logic                 slot_free;    // empty now or emptying this cycle
   logic                 take_test;
   logic                 take_norm;
   etx_pkg::etx_packet_t next_packet;

   assign slot_free = ~sel_valid | sel_ready;
   assign tx_ready  = slot_free & ~test_access & tx_enable;
   assign take_test = test_access & slot_free;
   assign take_norm = tx_access & tx_ready;

   // #################### rewrites
   always_comb
   begin
      next_packet = test_access ? test_packet : tx_packet;
      if (ctrlmode_bp)
         next_packet.ctrlmode = ctrlmode;   // config value replaces tag
      if (remap_enable)
         next_packet.dstaddr[31:20] = CHIP_ID;   // local chip base
   end

   // #################### entry state
   always_ff @(posedge sys_clk or posedge reset)
   begin
      if (reset)
      begin
         sel_valid <= 1'b0;
         test_drop <= 1'b0;
      end
      else
      begin
         if (take_test || take_norm)
            sel_valid <= 1'b1;
         else if (sel_ready)
            sel_valid <= 1'b0;   // handed to output stage
         test_drop <= test_access & ~slot_free;   // one cycle per lost request
      end
   end

   // payload, only meaningful while sel_valid
   always_ff @(posedge sys_clk)
   begin
      if (take_test || take_norm)
         sel_packet <= next_packet;
   end

endmodule

// File: etx/etx_out_stage.sv
/*
 drives the 9 link pins: framed bytes, gpio value or 1/0 pattern
 packets only accepted when idle and in normal mode, one idle cycle between frames
 link_wait repeats the current byte, so frame length is not fixed
*/
`timescale 1ns/100ps

module etx_out_stage
(
   input  logic                           sys_clk,
   input  logic                           reset,
   input  logic                           sel_valid,
   input  etx_pkg::etx_packet_t           sel_packet,
   output logic                           sel_ready,
   input  logic [1:0]                     pin_mode,
   input  logic [etx_pkg::gpio_width-1:0] gpio_data,
   input  logic                           test_drop,
   input  logic                           link_wait,
   output logic                           link_frame,
   output logic [7:0]                     link_data,
   output etx_pkg::etx_debug_t            tx_debug
);

   localparam int cnt_width = $clog2(etx_pkg::pkt_bytes);
   localparam logic [cnt_width-1:0] last_idx = cnt_width'(etx_pkg::pkt_bytes - 1);

   logic                          busy;          // frame in progress
   logic [cnt_width-1:0]          byte_cnt;
   logic [etx_pkg::pkt_width-1:0] shift_reg;     // current byte at the top
   logic                          normal_mode;
   logic                          advance;       // byte leaves this cycle
   logic                          pattern_phase;
   logic [etx_pkg::fcnt_width-1:0] frame_count;
   logic                          wait_seen;

   assign normal_mode = pin_mode != etx_pkg::pin_mode_gpio &&
                        pin_mode != etx_pkg::pin_mode_pattern;
   assign sel_ready   = ~busy & normal_mode;
   assign advance     = busy & ~link_wait;

   // #################### serializer
   always_ff @(posedge sys_clk or posedge reset)
   begin
      if (reset)
      begin
         busy        <= 1'b0;
         byte_cnt    <= '0;
         frame_count <= '0;
         wait_seen   <= 1'b0;
      end
      else
      begin
         if (sel_valid && sel_ready)
         begin
            busy     <= 1'b1;
            byte_cnt <= '0;
         end
         else if (advance)
         begin
            if (byte_cnt == last_idx)
            begin
               busy        <= 1'b0;
               frame_count <= frame_count + 1'b1;   // counted as last byte goes
            end
            else
               byte_cnt <= byte_cnt + 1'b1;
         end
         wait_seen <= busy & link_wait;   // stall during a frame
      end
   end

   always_ff @(posedge sys_clk)
   begin
      if (sel_valid && sel_ready)
         shift_reg <= sel_packet;
      else if (advance)
         shift_reg <= shift_reg << 8;   // msb first
   end

   // pattern starts at ones on entry, then toggles
   always_ff @(posedge sys_clk or posedge reset)
   begin
      if (reset)
         pattern_phase <= 1'b1;
      else if (pin_mode == etx_pkg::pin_mode_pattern)
         pattern_phase <= ~pattern_phase;
      else
         pattern_phase <= 1'b1;
   end

   // #################### pin mux
   always_comb
   begin
      case (pin_mode)
         etx_pkg::pin_mode_gpio:    {link_frame, link_data} = gpio_data;   // bit 8 is frame
         etx_pkg::pin_mode_pattern: {link_frame, link_data} = {9{pattern_phase}};
         default:
            {link_frame, link_data} = busy ? {1'b1, shift_reg[etx_pkg::pkt_width-1 -: 8]}
                                           : 9'd0;
      endcase
   end

   assign tx_debug = '{frame_count: frame_count, test_dropped: test_drop,
                       wait_seen: wait_seen, spare: 1'b0};

endmodule

// File: rtl/etx_top.sv
/*
 transmit side of the link: config registers, packet selector, pin driver
 single clock domain, no mmu translation, no ddr pins
*/
`timescale 1ns/100ps

module etx_top
#(
   parameter logic [etx_pkg::group_width-1:0] GROUP   = '0,
   parameter logic [11:0]                     CHIP_ID = 12'h808   // remap base
)
(
   input  logic                           sys_clk,
   input  logic                           reset,
   input  logic                           mi_en,
   input  logic                           mi_we,
   input  logic [etx_pkg::addr_width-1:0] mi_addr,
   input  logic [etx_pkg::data_width-1:0] mi_din,
   output logic [etx_pkg::data_width-1:0] mi_dout,
   input  logic                           tx_access,
   input  logic [etx_pkg::pkt_width-1:0]  tx_packet,
   output logic                           tx_ready,
   input  logic                           link_wait,
   output logic                           link_frame,
   output logic [7:0]                     link_data
);

   logic                           tx_enable;
   logic                           remap_enable;
   logic                           ctrlmode_bp;
   logic [3:0]                     ctrlmode;
   logic [1:0]                     pin_mode;
   logic [etx_pkg::gpio_width-1:0] gpio_data;
   logic                           test_access;
   etx_pkg::etx_packet_t           test_packet;
   etx_pkg::etx_debug_t            tx_debug;
   logic                           sel_valid;
   etx_pkg::etx_packet_t           sel_packet;
   logic                           sel_ready;
   logic                           test_drop;

   // #################### bus
   mi_if mi_i ();

   assign mi_i.en   = mi_en;
   assign mi_i.we   = mi_we;
   assign mi_i.addr = mi_addr;
   assign mi_i.din  = mi_din;
   assign mi_dout   = mi_i.dout;

   ecfg_tx #(.GROUP(GROUP)) ecfg_tx_i
   (
      .sys_clk, .reset, .mi(mi_i.slave), .tx_debug, .tx_enable, .remap_enable,
      .ctrlmode_bp, .ctrlmode, .pin_mode, .gpio_data, .test_access, .test_packet
   );

   // #################### datapath
   etx_packet_sel #(.CHIP_ID(CHIP_ID)) etx_packet_sel_i
   (
      .sys_clk, .reset, .tx_access, .tx_packet(etx_pkg::etx_packet_t'(tx_packet)),
      .tx_ready, .test_access, .test_packet, .tx_enable, .remap_enable, .ctrlmode_bp,
      .ctrlmode, .sel_valid, .sel_packet, .sel_ready, .test_drop
   );

   etx_out_stage etx_out_stage_i
   (
      .sys_clk, .reset, .sel_valid, .sel_packet, .sel_ready, .pin_mode, .gpio_data,
      .test_drop, .link_wait, .link_frame, .link_data, .tx_debug
   );

endmodule

// File: test/etx_clkgen.sv
/*
 testbench clock and reset source
 reset is released 1 ns after the last reset edge, never at an edge
*/
`timescale 1ns/100ps

module etx_clkgen
#(
   parameter int half_period  = 4,   // 8 ns clock
   parameter int reset_cycles = 4
)
(
   output logic sys_clk,
   output logic reset
);

   initial
   begin
      sys_clk = 1'b0;
      forever
         #(half_period) sys_clk = ~sys_clk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge sys_clk);
      #1 reset = 1'b0;   // clear of the edge
   end

endmodule

// File: test/tb_etx.sv
/*
 directed tests for the link transmit path, one task per behavior
 inputs change 1 ns after the rising edge, outputs are sampled 3 ns after it
 expected frames come from the packet layout and the rewrite rules only
*/
`timescale 1ns/100ps

module tb_etx;

   localparam logic [3:0]  group_id  = 4'h3;     // DUT register group
   localparam logic [3:0]  other_grp = 4'h5;     // must be ignored
   localparam logic [11:0] chip_id   = 12'h808;  // remap base
   localparam int          max_wait  = 400;      // cycles per wait loop

   logic         sys_clk;
   logic         reset;
   logic         mi_en;
   logic         mi_we;
   logic [19:0]  mi_addr;
   logic [31:0]  mi_din;
   logic [31:0]  mi_dout;
   logic         tx_access;
   logic [103:0] tx_packet;
   logic         tx_ready;
   logic         link_wait;
   logic         link_frame;
   logic [7:0]   link_data;

   integer       seed;
   int           mismatches;
   int           timeouts;
   int           frames_sent;      // frames seen on the pins so far
   int           accepted_cnt;     // normal packets handed to the selector
   int           frames_started;   // frames whose first byte was seen
   int           guard;
   logic [103:0] pkt_mem [0:7];    // packets to send
   logic [103:0] exp_mem [0:7];    // frames to expect

   etx_clkgen #(.half_period(4), .reset_cycles(4)) clkgen_i
   (
      .sys_clk,
      .reset
   );

   etx_top #(.GROUP(group_id), .CHIP_ID(chip_id)) etx_top_i
   (
      .sys_clk, .reset, .mi_en, .mi_we, .mi_addr, .mi_din, .mi_dout,
      .tx_access, .tx_packet, .tx_ready, .link_wait, .link_frame, .link_data
   );

   // #################### reporting
   task automatic note_mismatch(input string name, input logic [103:0] expected,
                                input logic [103:0] actual);
      mismatches++;
      $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
   endtask

   task automatic note_timeout(input string what);
      timeouts++;
      $display("timeout at %0t ns: %s", $time, what);
   endtask

   // #################### models
   function automatic logic [19:0] reg_addr(input logic [3:0] grp, input logic [3:0] idx);
      reg_addr = {grp, 10'd0, idx, 2'b00};   // group on top, word index
   endfunction

   // writable bits of each register index
   function automatic logic [31:0] field_mask(input int idx);
      case (idx)
         0:       field_mask = 32'h0000_07ff;   // cfg up to pin mode
         2, 3:    field_mask = 32'h0000_01ff;   // gpio, test
         4, 5, 6: field_mask = 32'hffff_ffff;
         default: field_mask = 32'd0;
      endcase
   endfunction

   // frame content after ctrlmode override and dstaddr remap
   function automatic logic [103:0] rewrite_packet(input logic [103:0] pkt,
                                                   input logic [31:0]  cfg);
      logic [103:0] res;
      res = pkt;
      if (cfg[8])
         res[4:1] = cfg[7:4];     // ctrlmode sits in ctrl byte bits 4:1
      if (cfg[3:2] == 2'b01)
         res[39:28] = chip_id;    // dstaddr[31:20]
      rewrite_packet = res;
   endfunction

   function automatic logic [103:0] random_packet();
      random_packet = {$random(seed), $random(seed), $random(seed), 8'($random(seed))};
   endfunction

   // #################### bus
   task automatic mi_write(input logic [3:0] grp, input logic [3:0] idx,
                           input logic [31:0] data);
      @(posedge sys_clk);
      #1;
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = reg_addr(grp, idx);
      mi_din  = data;
      @(posedge sys_clk);   // register takes it here
      #1;
      mi_en   = 1'b0;
      mi_we   = 1'b0;
   endtask

   task automatic mi_read(input logic [3:0] grp, input logic [3:0] idx,
                          output logic [31:0] data);
      @(posedge sys_clk);
      #1;
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = reg_addr(grp, idx);
      @(posedge sys_clk);
      #1;
      mi_en   = 1'b0;
      data    = mi_dout;   // one cycle latency
   endtask

   task automatic read_check(input logic [3:0] idx, input logic [31:0] expected);
      logic [31:0] data;
      mi_read(group_id, idx, data);
      if (data !== expected)
         note_mismatch($sformatf("mi_dout reg %0d", idx), expected, data);
   endtask

   // frame count in 15:3, sticky debug bits in 2:0
   task automatic status_check(input logic [2:0] sticky);
      logic [31:0] data;
      mi_read(group_id, etx_pkg::reg_status, data);
      if (data[15:3] !== 13'(frames_sent))
         note_mismatch("status frame_count", frames_sent, data[15:3]);
      if (data[2:0] !== sticky)
         note_mismatch("status sticky bits", sticky, data[2:0]);
   endtask

   // #################### packet stream
   task automatic send_packets(input int count);
      int   sent;
      int   wait_cnt;
      logic ready;
      sent     = 0;
      wait_cnt = 0;
      @(posedge sys_clk);
      #1;
      while (sent < count && wait_cnt <= max_wait)
      begin
         tx_access = 1'b1;
         tx_packet = pkt_mem[sent];
         #1;
         ready = tx_ready;   // transfer at the coming edge
         @(posedge sys_clk);
         #1;
         if (ready)
         begin
            accepted_cnt++;   // now sitting in the entry
            sent++;
            wait_cnt = 0;
         end
         else
            wait_cnt++;
      end
      tx_access = 1'b0;
      if (sent < count)
         note_timeout("tx_ready never rose for a pending packet");
   endtask

   // gathers bytes on frame cycles without wait, stall adds random link_wait
   task automatic collect_frame(input bit stall, output logic [103:0] got,
                                output int nbytes);
      int          wait_cnt;
      bit          started;
      bit          done;
      bit          forced;
      logic [31:0] r;
      wait_cnt = 0;
      started  = 0;
      done     = 0;
      forced   = 0;
      nbytes   = 0;
      got      = '0;
      while (!done)
      begin
         @(posedge sys_clk);
         #1;
         r = $random(seed);
         // at least one stall per frame, at byte 3
         link_wait = stall && link_frame && (r[1:0] == 2'd0 || (nbytes == 3 && !forced));
         if (link_wait)
            forced = 1;
         #2;
         if (link_frame && !started)
         begin
            started = 1;
            frames_started++;
         end
         if (started && !link_frame)
            done = 1;   // frame bit fell
         else if (started && link_wait)
         begin
            // next packet waits in the entry, nothing more may be taken
            if (accepted_cnt > frames_started && tx_ready !== 1'b0)
               note_mismatch("tx_ready during stall", 1'b0, tx_ready);
         end
         else if (started)
         begin
            got = {got[95:0], link_data};   // msb first
            nbytes++;
         end
         wait_cnt++;
         if (wait_cnt > max_wait && !done)
         begin
            note_timeout("no complete frame on link_frame");
            done = 1;
         end
      end
   endtask

   task automatic expect_frame(input logic [103:0] expected, input bit stall);
      logic [103:0] got;
      int           nbytes;
      collect_frame(stall, got, nbytes);
      if (nbytes != 13)
         note_mismatch("frame byte count", 13, nbytes);
      else if (got !== expected)
         note_mismatch("link_data frame", expected, got);
      frames_sent++;
   endtask

   task automatic frame_stream(input int count, input bit stall);
      accepted_cnt   = 0;
      frames_started = 0;
      fork
         send_packets(count);
         begin
            for (int i = 0; i < count; i++)
               expect_frame(exp_mem[i], stall);
         end
      join
   endtask

   // counts frame starts until the pins stay idle for 30 cycles
   task automatic wait_quiet(output int nframes);
      int   quiet;
      int   wait_cnt;
      logic prev;
      quiet    = 0;
      wait_cnt = 0;
      prev     = 1'b0;
      nframes  = 0;
      while (quiet < 30 && wait_cnt < max_wait)
      begin
         @(posedge sys_clk);
         #3;
         if (link_frame && !prev)
            nframes++;
         quiet = link_frame ? 0 : quiet + 1;
         prev  = link_frame;
         wait_cnt++;
      end
      if (quiet < 30)
         note_timeout("link pins never went idle");
   endtask

   // #################### tests
   task automatic after_reset();
      @(posedge sys_clk);
      #3;
      if (tx_ready !== 1'b0)
         note_mismatch("tx_ready", 1'b0, tx_ready);
      if (link_frame !== 1'b0)
         note_mismatch("link_frame", 1'b0, link_frame);
      if (link_data !== 8'd0)
         note_mismatch("link_data", 8'd0, link_data);
      for (int i = 0; i < 16; i++)
         read_check(4'(i), 32'd0);   // status included
   endtask

   task automatic register_access();
      logic [31:0] vals [0:15];
      logic [31:0] data;
      for (int i = 0; i < 16; i++)
         vals[i] = $random(seed);
      vals[3] = vals[3] & ~32'h101;   // no test launch, no loop
      for (int i = 0; i < 16; i++)
      begin
         if (i != 1)
            mi_write(group_id, 4'(i), vals[i]);
      end
      for (int i = 0; i < 16; i++)
      begin
         if (i != 1)
            read_check(4'(i), vals[i] & field_mask(i));   // unlisted read zero
      end
      // foreign group, writes and reads ignored
      mi_write(other_grp, etx_pkg::reg_cfg, ~vals[0]);
      mi_write(other_grp, etx_pkg::reg_data, ~vals[5]);
      read_check(etx_pkg::reg_cfg, vals[0] & field_mask(0));
      mi_read(other_grp, etx_pkg::reg_data, data);
      if (data !== (vals[0] & field_mask(0)))
         note_mismatch("mi_dout after foreign read", vals[0] & field_mask(0), data);
      read_check(etx_pkg::reg_data, vals[5]);
      for (int i = 0; i < 7; i++)
      begin
         if (i != 1)
            mi_write(group_id, 4'(i), 32'd0);
      end
   endtask

   task automatic tx_disabled();
      mi_write(group_id, etx_pkg::reg_cfg, 32'd0);
      tx_packet = random_packet();
      tx_access = 1'b1;
      for (int cyc = 0; cyc < 30; cyc++)
      begin
         #2;
         if (tx_ready !== 1'b0)
            note_mismatch("tx_ready while disabled", 1'b0, tx_ready);
         if (link_frame !== 1'b0)
            note_mismatch("link_frame while disabled", 1'b0, link_frame);
         @(posedge sys_clk);
         #1;
      end
      tx_access = 1'b0;
      status_check(3'b000);
   endtask

   task automatic normal_frames();
      logic [31:0] cfg;
      cfg = 32'h1;   // tx on, no rewrites
      mi_write(group_id, etx_pkg::reg_cfg, cfg);
      for (int i = 0; i < 3; i++)
      begin
         pkt_mem[i] = random_packet();
         exp_mem[i] = rewrite_packet(pkt_mem[i], cfg);
      end
      frame_stream(3, 0);
      // ctrlmode override plus remap
      cfg = 32'h105 | ($random(seed) & 32'hf0);
      mi_write(group_id, etx_pkg::reg_cfg, cfg);
      for (int i = 0; i < 3; i++)
      begin
         pkt_mem[i] = random_packet();
         exp_mem[i] = rewrite_packet(pkt_mem[i], cfg);
      end
      frame_stream(3, 0);
      status_check(3'b000);
   endtask

   task automatic back_pressure();
      mi_write(group_id, etx_pkg::reg_cfg, 32'h1);
      for (int i = 0; i < 4; i++)
      begin
         pkt_mem[i] = random_packet();
         exp_mem[i] = pkt_mem[i];
      end
      frame_stream(4, 1);
      status_check(3'b010);   // wait_seen
      repeat (5) @(posedge sys_clk);
      status_check(3'b010);   // still sticky
   endtask

   task automatic test_packet_path();
      logic [31:0]  cfg;
      logic [31:0]  dst;
      logic [31:0]  dat;
      logic [31:0]  src;
      logic [31:0]  ctrl;
      logic [103:0] expected;
      int           nframes;
      cfg  = 32'h105 | ($random(seed) & 32'hf0);
      dst  = $random(seed);
      dat  = $random(seed);
      src  = $random(seed);
      ctrl = $random(seed) & 32'hfe;
      mi_write(group_id, etx_pkg::reg_cfg, cfg);
      mi_write(group_id, etx_pkg::reg_dstaddr, dst);
      mi_write(group_id, etx_pkg::reg_data, dat);
      mi_write(group_id, etx_pkg::reg_srcaddr, src);
      mi_write(group_id, etx_pkg::reg_test, ctrl);
      // single shot, bit 0 ends up in the ctrl byte
      expected = rewrite_packet({src, dat, dst, ctrl[7:0] | 8'h01}, cfg);
      mi_write(group_id, etx_pkg::reg_test, ctrl | 32'h1);
      expect_frame(expected, 0);
      wait_quiet(nframes);
      if (nframes != 0)
         note_mismatch("extra test frames", 0, nframes);
      status_check(3'b010);
      // loop mode
      expected = rewrite_packet({src, dat, dst, ctrl[7:0]}, cfg);
      mi_write(group_id, etx_pkg::reg_test, ctrl | 32'h100);
      repeat (3) expect_frame(expected, 0);
      mi_write(group_id, etx_pkg::reg_test, 32'd0);
      wait_quiet(nframes);   // frames already in flight
      frames_sent += nframes;
      status_check(3'b110);   // loop overran the full entry
   endtask

   task automatic pin_modes();
      logic [31:0]  gpio;
      logic [103:0] pkt;
      logic [8:0]   pattern;
      int           taken;
      mi_write(group_id, etx_pkg::reg_cfg, 32'h201);   // gpio mode, tx on
      gpio = $random(seed) & 32'h1ff;
      mi_write(group_id, etx_pkg::reg_gpio, gpio);
      pkt       = random_packet();
      tx_packet = pkt;
      tx_access = 1'b1;
      taken     = 0;
      for (int cyc = 0; cyc < 20; cyc++)
      begin
         #1;
         if (tx_ready)
            taken++;
         #1;
         if ({link_frame, link_data} !== gpio[8:0])
            note_mismatch("link pins in gpio mode", gpio[8:0], {link_frame, link_data});
         @(posedge sys_clk);
         #1;
      end
      tx_access = 1'b0;
      if (taken != 1)
         note_mismatch("packets taken into entry", 1, taken);   // entry only
      mi_write(group_id, etx_pkg::reg_cfg, 32'h401);   // pattern mode
      for (int cyc = 0; cyc < 12; cyc++)
      begin
         #2;
         pattern = (cyc % 2 == 0) ? 9'h1ff : 9'h000;
         if ({link_frame, link_data} !== pattern)
            note_mismatch("link pins in pattern mode", pattern, {link_frame, link_data});
         if (tx_ready !== 1'b0)
            note_mismatch("tx_ready with full entry", 1'b0, tx_ready);
         @(posedge sys_clk);
         #1;
      end
      // held packet leaves once normal mode returns
      mi_write(group_id, etx_pkg::reg_cfg, 32'h1);
      expect_frame(pkt, 0);
      status_check(3'b110);
   endtask

   // #################### sequence
   initial
   begin
      seed        = 45;
      mismatches  = 0;
      timeouts    = 0;
      frames_sent = 0;
      mi_en       = 1'b0;
      mi_we       = 1'b0;
      mi_addr     = '0;
      mi_din      = '0;
      tx_access   = 1'b0;
      tx_packet   = '0;
      link_wait   = 1'b0;
      guard       = 0;
      while (reset !== 1'b0 && guard < 50)
      begin
         @(posedge sys_clk);
         guard++;
      end
      if (reset !== 1'b0)
         note_timeout("reset was never released");
      after_reset();
      register_access();
      tx_disabled();
      normal_frames();
      back_pressure();
      test_packet_path();
      pin_modes();
      $display("errors %0d: %0d value mismatches, %0d timeouts",
               mismatches + timeouts, mismatches, timeouts);
      if (mismatches + timeouts == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   // run limit, far beyond the longest sequence
   initial
   begin
      #1_000_000;
      $display("simulation limit reached before the tests finished");
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: project.f
common/etx_pkg.sv
common/mi_if.sv
ecfg/ecfg_tx.sv
etx/etx_packet_sel.sv
etx/etx_out_stage.sv
rtl/etx_top.sv
test/etx_clkgen.sv
test/tb_etx.sv

// File: Bender.yml
package:
  name: etx

sources:
  - common/etx_pkg.sv
  - common/mi_if.sv
  - ecfg/ecfg_tx.sv
  - etx/etx_packet_sel.sv
  - etx/etx_out_stage.sv
  - rtl/etx_top.sv
  - target: test
    files:
      - test/etx_clkgen.sv
      - test/tb_etx.sv
